// File: hw/icache_pkg.sv
// geometry is fixed here, since every packed struct below derives from it
// addresses are physical, and a line is refilled as one incrementing burst of LINE_WORDS beats

package icache_pkg;

  // ============================================================
  // geometry
  // ============================================================
  localparam int ADDR_W     = 32;
  localparam int WAY_NUM    = 2;
  localparam int SET_NUM    = 16;
  localparam int LINE_WORDS = 4;
  localparam int OFS_W      = $clog2(LINE_WORDS * 4);
  localparam int IDX_W      = $clog2(SET_NUM);
  localparam int TAG_W      = ADDR_W - IDX_W - OFS_W;

  // ============================================================
  // payloads
  // ============================================================
  typedef logic [31:0] word_t;

  typedef word_t [LINE_WORDS-1:0] line_t;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
  } tag_entry_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    word_t             instr;
    logic              adef;   // misaligned fetch address
  } fetch_rsp_t;

  // read burst request, len is beats minus one
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
  } rd_addr_t;

  typedef struct packed {
    word_t data;
    logic  last;
  } rd_data_t;

  // way to replace next in a set
  typedef logic plru_t;

endpackage

// File: hw/icache_sdp_ram.sv
// flip-flop store, one write and one registered read port, write-first on an address match
// all entries read as zero after reset

`timescale 1ns/1ns

module icache_sdp_ram #(
  parameter int  DEPTH   = 16,
  parameter type entry_t = logic [31:0]
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  entry_t                   wdata_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output entry_t                   rdata_o
);

  entry_t mem [DEPTH];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
      rdata_o <= '0;
    end else begin
      if (we_i) begin
        mem[waddr_i] <= wdata_i;
      end
      // bypass so a read of the written entry sees the new value
      if (we_i && (waddr_i == raddr_i)) begin
        rdata_o <= wdata_i;
      end else begin
        rdata_o <= mem[raddr_i];
      end
    end
  end

endmodule

// File: hw/icache_refill.sv
// one line refill at a time, misses raised while busy are ignored
// memory must send exactly LINE_WORDS beats with last on the final one

`timescale 1ns/1ns

module icache_refill (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          miss_i,
  input  logic [icache_pkg::ADDR_W-1:0] miss_addr_i,
  output logic                          refill_busy_o,
  output logic                          refill_done_o,
  output icache_pkg::line_t             refill_line_o,
  output logic                          ar_valid_o,
  output icache_pkg::rd_addr_t          ar_o,
  input  logic                          ar_ready_i,
  input  logic                          r_valid_i,
  input  icache_pkg::rd_data_t          r_i,
  output logic                          r_ready_o
);

  localparam int BEAT_W = $clog2(icache_pkg::LINE_WORDS);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,   // ar valid, waiting for ready
    ST_DATA    // collecting beats
  } state_e;

  state_e                        state_q;
  logic [BEAT_W-1:0]             beat_q;
  logic [icache_pkg::ADDR_W-1:0] addr_q;
  icache_pkg::line_t             buf_q;
  logic                          beat_fire;

  assign beat_fire = r_valid_i && r_ready_o;

  // ============================================================
  // state machine
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      beat_q  <= '0;
    end else begin
      case (state_q)
        ST_IDLE: if (miss_i) state_q <= ST_ADDR;
        ST_ADDR: if (ar_ready_i) state_q <= ST_DATA;
        ST_DATA: if (beat_fire && r_i.last) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
      if (state_q != ST_DATA) begin
        beat_q <= '0;
      end else if (beat_fire) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && miss_i) begin
      addr_q <= miss_addr_i;
    end
    if (beat_fire) begin
      buf_q[beat_q] <= r_i.data;
    end
  end

  // ============================================================
  // outputs
  // ============================================================
  assign ar_valid_o    = state_q == ST_ADDR;
  assign ar_o.addr     = addr_q;
  assign ar_o.len      = 8'(icache_pkg::LINE_WORDS - 1);
  assign r_ready_o     = state_q == ST_DATA;
  assign refill_busy_o = state_q != ST_IDLE;
  assign refill_done_o = beat_fire && r_i.last;

  // final beat goes straight into the line so it is whole in the done cycle
  always_comb begin
    for (int w = 0; w < icache_pkg::LINE_WORDS; w++) begin
      if (beat_fire && (beat_q == BEAT_W'(w))) begin
        refill_line_o[w] = r_i.data;
      end else begin
        refill_line_o[w] = buf_q[w];
      end
    end
  end

endmodule

// File: hw/icache_pipeline.sv
// two-stage fetch pipeline, one outstanding miss and no new request while a refill runs
// flush drops stage 1 and any request accepted in the same cycle

`timescale 1ns/1ns

module icache_pipeline (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush_i,
  input  logic                   req_valid_i,
  input  icache_pkg::fetch_req_t req_i,
  output logic                   req_ready_o,
  output logic                   rsp_valid_o,
  output icache_pkg::fetch_rsp_t rsp_o,
  input  logic                   rsp_ready_i,
  output logic                   miss_o,
  output logic [icache_pkg::ADDR_W-1:0] miss_addr_o,
  input  logic                   refill_busy_i,
  input  logic                   refill_done_i,
  input  icache_pkg::line_t      refill_line_i
);

  localparam int WORD_W = $clog2(icache_pkg::LINE_WORDS);

  logic                          s1_valid;
  logic                          s1_adef;
  logic [icache_pkg::ADDR_W-1:0] s1_addr;
  logic                          s1_free;
  logic                          s1_adv;
  logic                          req_adef;
  logic [icache_pkg::IDX_W-1:0]  req_idx;
  logic [icache_pkg::IDX_W-1:0]  s1_idx;
  logic [icache_pkg::IDX_W-1:0]  rd_idx;
  logic [icache_pkg::TAG_W-1:0]  s1_tag;
  logic [WORD_W-1:0]             s1_word;

  icache_pkg::tag_entry_t        tag_rd  [icache_pkg::WAY_NUM];
  icache_pkg::line_t             line_rd [icache_pkg::WAY_NUM];
  icache_pkg::tag_entry_t        tag_wdata;
  logic [icache_pkg::WAY_NUM-1:0] hit_oh;
  logic [icache_pkg::WAY_NUM-1:0] way_we;
  logic                          hit;
  logic                          rsp_take;
  logic                          install;
  icache_pkg::plru_t             hit_way;
  icache_pkg::plru_t             victim;
  icache_pkg::plru_t             plru_wdata;
  icache_pkg::plru_t             plru_rd;
  logic                          plru_we;

  // ============================================================
  // stage 0
  // ============================================================
  assign req_adef = req_i.addr[1:0] != 2'b00;
  assign req_idx  = req_i.addr[icache_pkg::OFS_W +: icache_pkg::IDX_W];

  assign rsp_take    = rsp_valid_o && rsp_ready_i;
  assign s1_free     = !s1_valid || rsp_take;
  assign s1_adv      = s1_free && !refill_busy_i;
  assign req_ready_o = s1_adv;

  // stalled stage 1 keeps its own set on the read port
  assign rd_idx = s1_adv ? req_idx : s1_idx;

  // ============================================================
  // stage 1
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else if (flush_i) begin
      s1_valid <= 1'b0;
    end else if (s1_adv) begin
      s1_valid <= req_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_adv && req_valid_i) begin
      s1_addr <= req_i.addr;
      s1_adef <= req_adef;
    end
  end

  assign s1_idx  = s1_addr[icache_pkg::OFS_W +: icache_pkg::IDX_W];
  assign s1_tag  = s1_addr[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
  assign s1_word = s1_addr[2 +: WORD_W];

  // tag compare, at most one way matches
  always_comb begin
    for (int w = 0; w < icache_pkg::WAY_NUM; w++) begin
      hit_oh[w] = tag_rd[w].valid && (tag_rd[w].tag == s1_tag);
    end
  end

  assign hit     = |hit_oh;
  assign hit_way = hit_oh[1];
  assign victim  = plru_rd;

  assign rsp_valid_o = s1_valid && (s1_adef || hit);
  assign rsp_o.addr  = s1_addr;
  assign rsp_o.adef  = s1_adef;
  assign rsp_o.instr = s1_adef ? '0 : line_rd[hit_way][s1_word];

  assign miss_o      = s1_valid && !s1_adef && !hit;
  assign miss_addr_o = {s1_addr[icache_pkg::ADDR_W-1:icache_pkg::OFS_W],
                        {icache_pkg::OFS_W{1'b0}}};

  // ============================================================
  // install and replacement
  // ============================================================
  assign install   = refill_done_i && s1_valid && !s1_adef && !flush_i;
  assign tag_wdata = '{valid: 1'b1, tag: s1_tag};

  always_comb begin
    for (int w = 0; w < icache_pkg::WAY_NUM; w++) begin
      way_we[w] = install && (victim == icache_pkg::plru_t'(w));
    end
  end

  // point away from the way just used or just filled
  assign plru_we    = (rsp_take && !s1_adef) || install;
  assign plru_wdata = install ? ~victim : ~hit_way;

  for (genvar w = 0; w < icache_pkg::WAY_NUM; w++) begin : g_way
    icache_sdp_ram #(
      .DEPTH   (icache_pkg::SET_NUM),
      .entry_t (icache_pkg::tag_entry_t)
    ) u_tag_ram (
      .clk     (clk),
      .rst_n   (rst_n),
      .we_i    (way_we[w]),
      .waddr_i (s1_idx),
      .wdata_i (tag_wdata),
      .raddr_i (rd_idx),
      .rdata_o (tag_rd[w])
    );

    icache_sdp_ram #(
      .DEPTH   (icache_pkg::SET_NUM),
      .entry_t (icache_pkg::line_t)
    ) u_data_ram (
      .clk     (clk),
      .rst_n   (rst_n),
      .we_i    (way_we[w]),
      .waddr_i (s1_idx),
      .wdata_i (refill_line_i),
      .raddr_i (rd_idx),
      .rdata_o (line_rd[w])
    );
  end

  icache_sdp_ram #(
    .DEPTH   (icache_pkg::SET_NUM),
    .entry_t (icache_pkg::plru_t)
  ) u_plru_ram (
    .clk     (clk),
    .rst_n   (rst_n),
    .we_i    (plru_we),
    .waddr_i (s1_idx),
    .wdata_i (plru_wdata),
    .raddr_i (rd_idx),
    .rdata_o (plru_rd)
  );

endmodule

// File: hw/icache_top.sv
// 2-way instruction cache, one 32-bit word per fetch, physical addresses only
// read-only bus side, one line burst outstanding at a time

`timescale 1ns/1ns

module icache_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush_i,
  // fetch request
  input  logic                   req_valid_i,
  input  icache_pkg::fetch_req_t req_i,
  output logic                   req_ready_o,
  // fetch response
  output logic                   rsp_valid_o,
  output icache_pkg::fetch_rsp_t rsp_o,
  input  logic                   rsp_ready_i,
  // read burst address
  output logic                   ar_valid_o,
  output icache_pkg::rd_addr_t   ar_o,
  input  logic                   ar_ready_i,
  // read data
  input  logic                   r_valid_i,
  input  icache_pkg::rd_data_t   r_i,
  output logic                   r_ready_o
);

  logic                          miss;
  logic [icache_pkg::ADDR_W-1:0] miss_addr;
  logic                          refill_busy;
  logic                          refill_done;
  icache_pkg::line_t             refill_line;

  icache_pipeline u_pipeline (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush_i),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .req_ready_o   (req_ready_o),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_o         (rsp_o),
    .rsp_ready_i   (rsp_ready_i),
    .miss_o        (miss),
    .miss_addr_o   (miss_addr),
    .refill_busy_i (refill_busy),
    .refill_done_i (refill_done),
    .refill_line_i (refill_line)
  );

  icache_refill u_refill (
    .clk           (clk),
    .rst_n         (rst_n),
    .miss_i        (miss),
    .miss_addr_i   (miss_addr),
    .refill_busy_o (refill_busy),
    .refill_done_o (refill_done),
    .refill_line_o (refill_line),
    .ar_valid_o    (ar_valid_o),
    .ar_o          (ar_o),
    .ar_ready_i    (ar_ready_i),
    .r_valid_i     (r_valid_i),
    .r_i           (r_i),
    .r_ready_o     (r_ready_o)
  );

endmodule

// File: verif/icache_assert.sv
// bus and response protocol checks, bound into every icache_top
// response hold is not required in a cycle with flush, which clears stage 1

`timescale 1ns/1ns

module icache_assert (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   flush_i,
  input logic                   ar_valid_i,
  input icache_pkg::rd_addr_t   ar_i,
  input logic                   ar_ready_i,
  input logic                   r_ready_i,
  input logic                   rsp_valid_i,
  input icache_pkg::fetch_rsp_t rsp_i,
  input logic                   rsp_ready_i
);

  int fail_cnt = 0;

  // address phase holds until memory takes it
  ar_hold : assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
    else begin
      fail_cnt++;
      $error("ar dropped or changed before ar_ready");
    end

  // response holds under back-pressure
  rsp_hold : assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid_i && !rsp_ready_i && !flush_i |=> rsp_valid_i && $stable(rsp_i))
    else begin
      fail_cnt++;
      $error("fetch response dropped or changed while rsp_ready was low");
    end

  // address and data phases never overlap
  ar_r_excl : assert property (@(posedge clk) disable iff (!rst_n)
    !(ar_valid_i && r_ready_i))
    else begin
      fail_cnt++;
      $error("ar_valid and r_ready high in the same cycle");
    end

endmodule

bind icache_top icache_assert u_assert (
  .clk         (clk),
  .rst_n       (rst_n),
  .flush_i     (flush_i),
  .ar_valid_i  (ar_valid_o),
  .ar_i        (ar_o),
  .ar_ready_i  (ar_ready_i),
  .r_ready_i   (r_ready_o),
  .rsp_valid_i (rsp_valid_o),
  .rsp_i       (rsp_o),
  .rsp_ready_i (rsp_ready_i)
);

// File: verif/tb_icache.sv
// random fetches over three tags and four sets, with beat gaps and response back-pressure
// flush is raised only while a refill is in its address phase

`timescale 1ns/1ns

module tb_icache;

  localparam int N_RANDOM   = 400;
  localparam int N_DIRECTED = 16;
  // worst case per fetch is a miss with beat gaps and back-pressure
  localparam int MAX_CYCLES = (N_RANDOM + N_DIRECTED) * 50;
  localparam int LINE_B     = icache_pkg::LINE_WORDS * 4;

  logic                   clk;
  logic                   rst_n;
  logic                   flush_i;
  logic                   req_valid_i;
  icache_pkg::fetch_req_t req_i;
  logic                   req_ready_o;
  logic                   rsp_valid_o;
  icache_pkg::fetch_rsp_t rsp_o;
  logic                   rsp_ready_i = 1'b1;
  logic                   ar_valid_o;
  icache_pkg::rd_addr_t   ar_o;
  logic                   ar_ready_i  = 1'b0;
  logic                   r_valid_i   = 1'b0;
  icache_pkg::rd_data_t   r_i         = '0;
  logic                   r_ready_o;

  // reference tag store and replacement bits
  logic [icache_pkg::TAG_W-1:0] m_tag   [icache_pkg::SET_NUM][2];
  logic                         m_valid [icache_pkg::SET_NUM][2];
  logic                         m_plru  [icache_pkg::SET_NUM];

  icache_pkg::fetch_rsp_t exp_q [$];
  logic [31:0]            burst_q [$];

  logic [31:0] stim_seed;
  logic [31:0] bus_seed   = ~32'h7b7c;
  logic [31:0] burst_addr = '0;
  int          beat       = 0;
  logic        bp_on;
  int          main_err;
  int          rsp_err    = 0;
  int          bus_err    = 0;
  int          checks     = 0;

  icache_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // memory content is a fixed mix of the word address
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] w;
    w = {2'b00, addr[31:2]};
    return (w * 32'h9e37_79b1) ^ {w[15:0], w[31:16]};
  endfunction

  function automatic logic [31:0] make_addr(input int tag, input int set, input int word);
    return (32'(tag + 16) << (icache_pkg::OFS_W + icache_pkg::IDX_W))
         | (32'(set) << icache_pkg::OFS_W)
         | (32'(word) << 2);
  endfunction

  function automatic int err_total();
    return main_err + rsp_err + bus_err;
  endfunction

  // ============================================================
  // reference model
  // ============================================================
  // a dropped fetch leaves tags and replacement bits untouched
  function automatic icache_pkg::fetch_rsp_t ref_fetch(input logic [31:0] addr,
                                                      input logic dropped,
                                                      output logic miss);
    icache_pkg::fetch_rsp_t       e;
    logic [icache_pkg::IDX_W-1:0] set;
    logic [icache_pkg::TAG_W-1:0] tag;
    int                           way;
    set    = addr[icache_pkg::OFS_W +: icache_pkg::IDX_W];
    tag    = addr[31 -: icache_pkg::TAG_W];
    e.addr = addr;
    e.adef = (addr[1:0] != 2'b00);
    e.instr = e.adef ? '0 : mem_word(addr);
    miss   = 1'b0;
    if (!e.adef) begin
      way = -1;
      for (int w = 0; w < 2; w++) begin
        if (m_valid[set][w] && (m_tag[set][w] == tag)) begin
          way = w;
        end
      end
      if (way < 0) begin
        miss = 1'b1;
        way  = int'(m_plru[set]);
      end
      if (!dropped) begin
        m_valid[set][way] = 1'b1;
        m_tag[set][way]   = tag;
        m_plru[set]       = (way == 0);
      end
    end
    return e;
  endfunction

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
  endtask

  // issues one fetch and returns on the falling edge after it is accepted
  task automatic fetch(input logic [31:0] addr, input logic drop);
    icache_pkg::fetch_rsp_t e;
    logic                   miss;
    e = ref_fetch(addr, drop, miss);
    if (miss) begin
      burst_q.push_back(addr & ~32'(LINE_B - 1));
    end
    if (!drop) begin
      exp_q.push_back(e);
    end
    req_i.addr  = addr;
    req_valid_i = 1'b1;
    do begin
      @(posedge clk);
    end while (!req_ready_o);
    @(negedge clk);
    req_valid_i = 1'b0;
    if (drop) begin
      while (!ar_valid_o) begin
        @(negedge clk);
      end
      flush_i = 1'b1;
      @(negedge clk);
      flush_i = 1'b0;
    end
  endtask

  task automatic drain();
    while (exp_q.size() != 0 || ar_valid_o || r_ready_o) begin
      @(negedge clk);
    end
    assert (burst_q.size() == 0) else begin
      $display("t=%0t %0d predicted bursts were never issued", $time, burst_q.size());
      main_err++;
      burst_q.delete();
    end
  endtask

  task automatic report(input string name, input int err0);
    int n;
    n = err_total() - err0;
    $display("test %-14s %s, %0d errors", name, (n == 0) ? "ok" : "FAIL", n);
  endtask

  // ============================================================
  // stimulus
  // ============================================================
  initial begin
    logic [31:0] a;
    int          err0;
    rst_n       = 1'b0;
    flush_i     = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    bp_on       = 1'b0;
    main_err    = 0;
    stim_seed   = 32'h7b7c;
    for (int s = 0; s < icache_pkg::SET_NUM; s++) begin
      m_valid[s] = '{1'b0, 1'b0};
      m_plru[s]  = 1'b0;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    err0 = err_total();
    a    = make_addr(0, 1, 2);
    fetch(a, 1'b0);
    fetch(a + 32'd4, 1'b0);
    fetch(a - 32'd8, 1'b0);
    drain();
    report("miss_then_hit", err0);

    // tag 0 is hit again, so tag 2 must replace tag 1 and not tag 0
    err0 = err_total();
    fetch(make_addr(0, 3, 0), 1'b0);
    fetch(make_addr(1, 3, 1), 1'b0);
    fetch(make_addr(0, 3, 2), 1'b0);
    fetch(make_addr(2, 3, 3), 1'b0);
    fetch(make_addr(0, 3, 1), 1'b0);
    fetch(make_addr(1, 3, 0), 1'b0);
    fetch(make_addr(2, 3, 0), 1'b0);
    drain();
    report("eviction", err0);

    err0 = err_total();
    fetch(make_addr(2, 7, 1) | 32'd2, 1'b0);
    fetch(make_addr(0, 1, 0) | 32'd1, 1'b0);
    drain();
    report("misaligned", err0);

    err0  = err_total();
    bp_on = 1'b1;
    for (int i = 0; i < N_RANDOM; i++) begin
      stim_seed = lcg(stim_seed);
      a = make_addr(int'(stim_seed[18:17]) % 3, int'(stim_seed[21:20]),
                    int'(stim_seed[23:22]));
      if (stim_seed[27:24] == 4'd0) begin
        a[1:0] = stim_seed[30:29] | 2'b01;
      end
      fetch(a, 1'b0);
      if (stim_seed[31] && stim_seed[16]) begin
        @(negedge clk);
      end
    end
    drain();
    bp_on = 1'b0;
    report("random", err0);

    // the dropped line must be fetched again
    err0 = err_total();
    a    = make_addr(1, 9, 3);
    fetch(a, 1'b1);
    drain();
    fetch(a, 1'b0);
    fetch(a - 32'd4, 1'b0);
    drain();
    report("flush", err0);

    main_err += i_dut.u_assert.fail_cnt;
    $display("done: %0d responses checked, %0d errors", checks, err_total());
    if (err_total() == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, a fetch or refill never completed", cycles);
    $display("sim failed");
    $finish;
  end

  // ============================================================
  // response checker and memory model
  // ============================================================
  always @(posedge clk) begin : rsp_check
    icache_pkg::fetch_rsp_t e;
    if (rsp_valid_o && rsp_ready_i) begin
      assert (exp_q.size() != 0) else begin
        $display("t=%0t response for %h with no fetch outstanding", $time, rsp_o.addr);
        rsp_err++;
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        checks++;
        assert (rsp_o.addr == e.addr) else begin
          mismatch("rsp_o.addr", rsp_o.addr, e.addr);
          rsp_err++;
        end
        assert (rsp_o.adef == e.adef) else begin
          mismatch("rsp_o.adef", 32'(rsp_o.adef), 32'(e.adef));
          rsp_err++;
        end
        if (!e.adef) begin
          assert (rsp_o.instr == e.instr) else begin
            mismatch("rsp_o.instr", rsp_o.instr, e.instr);
            rsp_err++;
          end
        end
      end
    end
  end

  always @(posedge clk) begin : bus_monitor
    logic [31:0] exp_addr;
    if (ar_valid_o && ar_ready_i) begin
      assert (burst_q.size() != 0) else begin
        $display("t=%0t burst to %h where the model predicts no miss", $time, ar_o.addr);
        bus_err++;
      end
      if (burst_q.size() != 0) begin
        exp_addr = burst_q.pop_front();
        assert (ar_o.addr == exp_addr) else begin
          mismatch("ar_o.addr", ar_o.addr, exp_addr);
          bus_err++;
        end
      end
      // one line is LINE_WORDS beats, len counts beats minus one
      assert (32'(ar_o.len) == 32'(icache_pkg::LINE_WORDS - 1)) else begin
        mismatch("ar_o.len", 32'(ar_o.len), 32'(icache_pkg::LINE_WORDS - 1));
        bus_err++;
      end
      burst_addr = ar_o.addr;
      beat       = 0;
    end
    if (r_valid_i && r_ready_o) begin
      beat++;
    end
  end

  // random ar delay, beat gaps and response back-pressure
  always @(negedge clk) begin
    bus_seed    = lcg(bus_seed);
    ar_ready_i  = ar_valid_o && (bus_seed[17:16] != 2'b00);
    r_valid_i   = r_ready_o && (bus_seed[20:19] != 2'b00);
    r_i.data    = mem_word(burst_addr + 32'(beat * 4));
    r_i.last    = (beat == icache_pkg::LINE_WORDS - 1);
    rsp_ready_i = !bp_on || (bus_seed[26:25] != 2'b00);
  end

endmodule

// File: filelist.f
hw/icache_pkg.sv
hw/icache_sdp_ram.sv
hw/icache_refill.sv
hw/icache_pipeline.sv
hw/icache_top.sv
verif/icache_assert.sv
verif/tb_icache.sv

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and decides the result from the log
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert --timing --top-module tb_icache -f filelist.f -o tb_icache
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_icache +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" "$LOG"; then
  exit 1
fi
if ! grep -q "sim passed" "$LOG"; then
  echo "no result line in $LOG"
  exit 1
fi
exit 0
